// ==== common/ber_pkg.sv ====
`default_nettype none

package ber_pkg;

    // PRBS63, x^63 + x^62 + 1
    localparam int PRBS_LEN = 63;

    // RS(544,514) style FEC with 10-bit symbols
    localparam int SYM_BITS   = 10;
    localparam int CW_SYMBOLS = 544;
    localparam int FEC_T      = 15;

    // interleave depth
    localparam int MAX_LANES = 4;

    // statistics counters
    localparam int CNT_W = 64;

    // derived widths
    localparam int BIT_IDX_W  = $clog2(SYM_BITS);
    localparam int LANE_IDX_W = $clog2(MAX_LANES);
    localparam int SYM_CNT_W  = $clog2(CW_SYMBOLS + 1);
    localparam int BIT_CNT_W  = $clog2(CW_SYMBOLS * SYM_BITS + 1);

    typedef logic [PRBS_LEN-1:0] prbs_state_t;

    // lane index, or lane count 1..MAX_LANES
    typedef logic [2:0] lane_t;

    // one compared bit
    typedef struct packed {
        logic valid;
        logic err;
    } bit_event_t;

    // closed codeword summary
    typedef struct packed {
        logic                 valid;
        logic [SYM_CNT_W-1:0] sym_errs;
        logic [BIT_CNT_W-1:0] bit_errs;
    } cw_result_t;

    typedef struct packed {
        logic [CNT_W-1:0] total_bits;
        logic [CNT_W-1:0] bit_errors_pre;
        logic [CNT_W-1:0] bit_errors_post;
        logic [CNT_W-1:0] frames;
        logic [CNT_W-1:0] frame_errors;
    } ber_stats_t;

endpackage

`default_nettype wire

// ==== logic/prbs63_lfsr.sv ====
`timescale 1ns/1ns
`default_nettype none

module prbs63_lfsr import ber_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire prbs_state_t seed,
    input  wire logic        advance,
    output logic             next_bit
);

    prbs_state_t sr;

    // feedback from taps 63 and 62, emitted as the output bit as well
    assign next_bit = sr[PRBS_LEN-1] ^ sr[PRBS_LEN-2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sr <= seed;
        end else if (advance) begin
            sr <= {sr[PRBS_LEN-2:0], next_bit};
        end
    end

endmodule

`default_nettype wire

// ==== prbs_gen/prbs_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module prbs_gen import ber_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        en,
    input  wire prbs_state_t seed,
    input  wire logic        tx_ready,
    output logic             tx_data,
    output logic             tx_valid
);

    logic lfsr_bit;
    logic load;

    // refill when the output slot is empty or drains this cycle
    assign load = en && (!tx_valid || tx_ready);

    prbs63_lfsr u_lfsr (
        .clk      (clk),
        .rstn     (rstn),
        .seed     (seed),
        .advance  (load),
        .next_bit (lfsr_bit)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_valid <= 1'b0;
        end else if (load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            // transfer with en low, slot goes empty
            tx_valid <= 1'b0;
        end
    end

    // data only changes on a refill, so it holds while waiting on ready
    always_ff @(posedge clk) begin
        if (load) begin
            tx_data <= lfsr_bit;
        end
    end

endmodule

`default_nettype wire

// ==== fec_checker/bit_compare.sv ====
`timescale 1ns/1ns
`default_nettype none

module bit_compare import ber_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire prbs_state_t seed,
    input  wire logic        rx_data,
    input  wire logic        rx_valid,
    output bit_event_t       evt
);

    logic ref_bit;

    // local reference, stepped once per received bit
    prbs63_lfsr u_ref (
        .clk      (clk),
        .rstn     (rstn),
        .seed     (seed),
        .advance  (rx_valid),
        .next_bit (ref_bit)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            evt <= '0;
        end else begin
            evt.valid <= rx_valid;
            evt.err   <= rx_valid && (rx_data != ref_bit);
        end
    end

endmodule

`default_nettype wire

// ==== fec_checker/symbol_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module symbol_tracker import ber_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire lane_t      n_lanes,
    input  wire bit_event_t evt,
    output cw_result_t      cw
);

    // per-lane progress
    logic [BIT_IDX_W-1:0] bit_idx  [MAX_LANES];
    logic                 sym_err  [MAX_LANES];
    logic [SYM_CNT_W-1:0] sym_idx  [MAX_LANES];
    logic [SYM_CNT_W-1:0] sym_errs [MAX_LANES];
    logic [BIT_CNT_W-1:0] bit_errs [MAX_LANES];

    lane_t                 lanes_q;
    lane_t                 cur;
    logic [LANE_IDX_W-1:0] li;

    // values of the active lane including the incoming bit
    logic                 sym_err_now;
    logic [SYM_CNT_W-1:0] sym_errs_now;
    logic [BIT_CNT_W-1:0] bit_errs_now;
    logic                 sym_done;
    logic                 cw_done;

    assign li = cur[LANE_IDX_W-1:0];

    always_comb begin
        sym_err_now  = sym_err[li] | evt.err;
        sym_errs_now = sym_errs[li] + SYM_CNT_W'(sym_err_now);
        bit_errs_now = bit_errs[li] + BIT_CNT_W'(evt.err);
        sym_done     = evt.valid && (bit_idx[li] == BIT_IDX_W'(SYM_BITS - 1));
        cw_done      = sym_done && (sym_idx[li] == SYM_CNT_W'(CW_SYMBOLS - 1));
    end

    // lane count sampled while in reset, kept within 1..MAX_LANES
    always_ff @(posedge clk) begin
        if (!rstn) begin
            if (n_lanes == '0) begin
                lanes_q <= lane_t'(1);
            end else if (n_lanes > lane_t'(MAX_LANES)) begin
                lanes_q <= lane_t'(MAX_LANES);
            end else begin
                lanes_q <= n_lanes;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cur <= '0;
            cw  <= '0;
            for (int i = 0; i < MAX_LANES; i++) begin
                bit_idx[i]  <= '0;
                sym_err[i]  <= 1'b0;
                sym_idx[i]  <= '0;
                sym_errs[i] <= '0;
                bit_errs[i] <= '0;
            end
        end else begin
            cw.valid <= 1'b0;
            if (evt.valid && !sym_done) begin
                bit_idx[li]  <= bit_idx[li] + 1'b1;
                sym_err[li]  <= sym_err_now;
                bit_errs[li] <= bit_errs_now;
            end
            if (sym_done) begin
                bit_idx[li] <= '0;
                sym_err[li] <= 1'b0;
                // round-robin to the next codeword of the interleave
                if (cur + lane_t'(1) >= lanes_q) begin
                    cur <= '0;
                end else begin
                    cur <= cur + lane_t'(1);
                end
            end
            if (sym_done && !cw_done) begin
                sym_idx[li]  <= sym_idx[li] + 1'b1;
                sym_errs[li] <= sym_errs_now;
                bit_errs[li] <= bit_errs_now;
            end
            if (cw_done) begin
                cw.valid     <= 1'b1;
                cw.sym_errs  <= sym_errs_now;
                cw.bit_errs  <= bit_errs_now;
                sym_idx[li]  <= '0;
                sym_errs[li] <= '0;
                bit_errs[li] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fec_checker/ber_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

module ber_stats import ber_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire bit_event_t evt,
    input  wire cw_result_t cw,
    output ber_stats_t      stats
);

    logic cw_fail;

    // decoder gives up past FEC_T bad symbols
    assign cw_fail = cw.valid && (cw.sym_errs > SYM_CNT_W'(FEC_T));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stats <= '0;
        end else begin
            // pre-FEC counts, one per compared bit
            if (evt.valid) begin
                stats.total_bits     <= stats.total_bits + 1'b1;
                stats.bit_errors_pre <= stats.bit_errors_pre + CNT_W'(evt.err);
            end

            if (cw.valid) begin
                stats.frames <= stats.frames + 1'b1;
            end

            // uncorrectable codeword, all its bit errors survive
            if (cw_fail) begin
                stats.frame_errors    <= stats.frame_errors + 1'b1;
                stats.bit_errors_post <= stats.bit_errors_post + CNT_W'(cw.bit_errs);
            end
        end
    end

endmodule

`default_nettype wire

// ==== fec_checker/fec_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module fec_checker import ber_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire prbs_state_t seed,
    input  wire lane_t       n_lanes,
    input  wire logic        rx_data,
    input  wire logic        rx_valid,
    output ber_stats_t       stats
);

    bit_event_t evt;
    cw_result_t cw;

    bit_compare u_compare (
        .clk      (clk),
        .rstn     (rstn),
        .seed     (seed),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .evt      (evt)
    );

    // symbols spread over the interleaved codewords
    symbol_tracker u_tracker (
        .clk     (clk),
        .rstn    (rstn),
        .n_lanes (n_lanes),
        .evt     (evt),
        .cw      (cw)
    );

    ber_stats u_stats (
        .clk   (clk),
        .rstn  (rstn),
        .evt   (evt),
        .cw    (cw),
        .stats (stats)
    );

endmodule

`default_nettype wire

// ==== logic/ber_tester_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ber_tester_top import ber_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        en,
    input  wire prbs_state_t seed,
    input  wire lane_t       n_lanes,
    output logic             tx_data,
    output logic             tx_valid,
    input  wire logic        tx_ready,
    input  wire logic        rx_data,
    input  wire logic        rx_valid,
    output ber_stats_t       stats
);

    // transmit pattern source
    prbs_gen u_gen (
        .clk      (clk),
        .rstn     (rstn),
        .en       (en),
        .seed     (seed),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    // receive side, same seed as the generator
    fec_checker u_checker (
        .clk      (clk),
        .rstn     (rstn),
        .seed     (seed),
        .n_lanes  (n_lanes),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .stats    (stats)
    );

endmodule

`default_nettype wire

// ==== test/ber_model.svh ====
`ifndef BER_MODEL_SVH
`define BER_MODEL_SVH

// one test case, see the table in ber_tb
typedef struct packed {
    lane_t       lanes;
    logic [7:0]  rounds;
    logic [15:0] burst;
    logic [3:0]  flips;
    logic        rand_ready;
    logic        all_fail;
    prbs_state_t seed;
} test_row_t;

// last PRBS_LEN output bits, oldest first
bit model_hist[$];

// seed bit 62 counts as the oldest bit of the history
function automatic void model_load(input prbs_state_t s);
    model_hist.delete();
    for (int i = PRBS_LEN - 1; i >= 0; i--) begin
        model_hist.push_back(s[i]);
    end
endfunction

// x^63 + x^62 + 1 as a recurrence: out[n] = out[n-63] ^ out[n-62]
function automatic bit model_next();
    bit b;
    b = model_hist[0] ^ model_hist[1];
    void'(model_hist.pop_front());
    model_hist.push_back(b);
    return b;
endfunction

function automatic int row_bits(input test_row_t row);
    return int'(row.lanes) * int'(row.rounds) * CW_SYMBOLS * SYM_BITS;
endfunction

// first burst symbols of every round, first flips bits of each such symbol
function automatic logic flip_bit(input test_row_t row, input int k);
    int pos;
    int sym;
    pos = k % (int'(row.lanes) * CW_SYMBOLS * SYM_BITS);
    sym = pos / SYM_BITS;
    return (sym < int'(row.burst)) && ((pos % SYM_BITS) < int'(row.flips));
endfunction

function automatic ber_stats_t expected_stats(input test_row_t row);
    ber_stats_t want;
    int lanes;
    int rounds;
    int se;
    want = '0;
    lanes = int'(row.lanes);
    rounds = int'(row.rounds);
    want.total_bits = CNT_W'(row_bits(row));
    want.bit_errors_pre = CNT_W'(int'(row.burst) * int'(row.flips) * rounds);
    want.frames = CNT_W'(lanes * rounds);
    for (int l = 0; l < lanes; l++) begin
        // round-robin share of the burst that lands in this lane
        se = 0;
        for (int g = l; g < int'(row.burst); g += lanes) begin
            se++;
        end
        if (se > FEC_T) begin
            want.frame_errors += CNT_W'(rounds);
            want.bit_errors_post += CNT_W'(se * int'(row.flips) * rounds);
        end
    end
    return want;
endfunction

`endif

// ==== test/ber_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ber_tb import ber_pkg::*;;

    logic        clk;
    logic        rstn;
    logic        en;
    prbs_state_t seed;
    lane_t       n_lanes;
    logic        tx_data;
    logic        tx_valid;
    logic        tx_ready;
    logic        rx_data;
    logic        rx_valid;
    ber_stats_t  stats;

    int     errors = 0;
    integer rand_seed = 73;

    `include "ber_model.svh"

    // lanes, rounds, burst symbols per round, flips per symbol,
    // random ready, every codeword fails, seed
    test_row_t rows [7] = '{
        '{3'd1, 8'd2, 16'd0,  4'd0,  1'b0, 1'b0, 63'h0000_0000_0000_0001},
        '{3'd2, 8'd1, 16'd30, 4'd3,  1'b0, 1'b0, 63'h1234_5678_9abc_def0},
        '{3'd3, 8'd1, 16'd48, 4'd2,  1'b0, 1'b1, 63'h2aaa_5555_0f0f_f0f0},
        '{3'd4, 8'd1, 16'd32, 4'd1,  1'b0, 1'b0, 63'h0000_0000_dead_beef},
        '{3'd1, 8'd2, 16'd32, 4'd1,  1'b0, 1'b1, 63'h0000_0000_dead_beef},
        '{3'd4, 8'd1, 16'd0,  4'd0,  1'b1, 1'b0, 63'h7fff_ffff_ffff_ffff},
        '{3'd2, 8'd1, 16'd34, 4'd10, 1'b1, 1'b1, 63'h0bad_cafe_0000_0001}
    };

    ber_tester_top dut (
        .clk      (clk),
        .rstn     (rstn),
        .en       (en),
        .seed     (seed),
        .n_lanes  (n_lanes),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .stats    (stats)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string name, input int idx,
                               input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] want);
        assert (got == want) else
            report_error($sformatf("row %0d: %s is %0d, expected %0d", idx, name, got, want));
    endtask

    task automatic run_row(input test_row_t row, input int idx);
        ber_stats_t want;
        int         total;
        int         sent;
        logic       xfer;
        logic       xfer_bit;
        logic       wait_prev;
        logic       wait_data;
        logic       model_bit;
        want = expected_stats(row);
        total = row_bits(row);
        model_load(row.seed);
        @(posedge clk);
        #1;
        rstn = 1'b0;
        en = 1'b0;
        tx_ready = 1'b0;
        rx_valid = 1'b0;
        rx_data = 1'b0;
        seed = row.seed;
        n_lanes = row.lanes;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        en = 1'b1;
        sent = 0;
        xfer = 1'b0;
        xfer_bit = 1'b0;
        wait_prev = 1'b0;
        wait_data = 1'b0;
        while (sent < total) begin
            @(posedge clk);
            #1;
            // loopback of the bit transferred at this edge
            rx_valid = xfer;
            rx_data = xfer_bit;
            tx_ready = row.rand_ready ? (($random(rand_seed) & 3) != 0) : 1'b1;
            @(negedge clk);
            if (wait_prev) begin
                assert (tx_valid && tx_data == wait_data) else
                    report_error($sformatf("row %0d: tx output changed while stalled", idx));
            end
            xfer = tx_valid && tx_ready;
            wait_prev = tx_valid && !tx_ready;
            wait_data = tx_data;
            if (xfer) begin
                model_bit = model_next();
                assert (tx_data == model_bit) else
                    report_error($sformatf("row %0d: tx bit %0d is %0b, expected %0b",
                                           idx, sent, tx_data, model_bit));
                xfer_bit = tx_data ^ flip_bit(row, sent);
                sent++;
            end
        end
        @(posedge clk);
        #1;
        rx_valid = xfer;
        rx_data = xfer_bit;
        tx_ready = 1'b0;
        en = 1'b0;
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        // drain the compare, tracker and stats pipeline
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_count("total_bits", idx, stats.total_bits, want.total_bits);
        check_count("bit_errors_pre", idx, stats.bit_errors_pre, want.bit_errors_pre);
        check_count("bit_errors_post", idx, stats.bit_errors_post, want.bit_errors_post);
        check_count("frames", idx, stats.frames, want.frames);
        check_count("frame_errors", idx, stats.frame_errors, want.frame_errors);
        if (row.all_fail) begin
            check_count("failed frames", idx, stats.frame_errors, want.frames);
            check_count("post errors vs pre", idx, stats.bit_errors_post, want.bit_errors_pre);
        end else begin
            check_count("failed frames", idx, stats.frame_errors, '0);
        end
    endtask

    initial begin
        rstn = 1'b0;
        en = 1'b0;
        seed = '0;
        n_lanes = lane_t'(1);
        tx_ready = 1'b0;
        rx_data = 1'b0;
        rx_valid = 1'b0;
        for (int r = 0; r < $size(rows); r++) begin
            run_row(rows[r], r);
        end
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // random ready stalls a quarter of the cycles, so twice the bit count is ample
    initial begin : watchdog
        int limit;
        limit = 0;
        for (int r = 0; r < $size(rows); r++) begin
            limit += 2 * row_bits(rows[r]) + 100;
        end
        repeat (limit) @(posedge clk);
        $display("ERROR at %0t ns: simulation hung, tests not done after %0d cycles",
                 $time, limit);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+test
common/ber_pkg.sv
logic/prbs63_lfsr.sv
prbs_gen/prbs_gen.sv
fec_checker/bit_compare.sv
fec_checker/symbol_tracker.sv
fec_checker/ber_stats.sv
fec_checker/fec_checker.sv
logic/ber_tester_top.sv
test/ber_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the BER tester testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ber_tb -f filelist.f -Mdir obj_dir -o ber_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ber_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
